//--- design/i2c_bus_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_params.svh"

module i2c_bus_timer (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                scl_in,  // scl pad readback
  output i2c_pkg::i2c_phase_t phase
);

  localparam logic [15:0] quarter     = 16'(`I2C_QUARTER);
  localparam logic [15:0] half        = 16'(2 * `I2C_QUARTER);
  localparam logic [15:0] period_last = 16'(4 * `I2C_QUARTER - 1);

  logic [15:0] count;       // position inside one SCL period
  logic        scl_level;
  logic        data_rise;
  logic        data_fall;
  logic        stretching;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count      <= '0;
      scl_level  <= 1'b0;
      data_rise  <= 1'b0;
      data_fall  <= 1'b0;
      stretching <= 1'b0;
    end else begin
      data_rise <= 1'b0;
      data_fall <= 1'b0;
      if (count == half && !scl_in) begin
        stretching <= 1'b1;  // SCL should be high here, so hold until the target lets go
      end else begin
        stretching <= 1'b0;
        count      <= (count == period_last) ? '0 : count + 16'd1;
        if (count == quarter - 16'd1)
          data_rise <= 1'b1;  // pulse lands on count == quarter
        if (count == half + quarter - 16'd1)
          data_fall <= 1'b1;  // pulse lands on count == 3 quarters
        if (count == half - 16'd1)
          scl_level <= 1'b1;
        else if (count == period_last)
          scl_level <= 1'b0;
      end
    end
  end

  assign phase = '{
    data_rise:  data_rise,
    data_fall:  data_fall,
    scl_level:  scl_level,
    stretching: stretching
  };

endmodule

`default_nettype wire

//--- design/i2c_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_engine (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                ena,            // held high while commands are pending
  input  i2c_pkg::i2c_cmd_t   cmd,
  input  i2c_pkg::i2c_phase_t phase,
  input  logic                sda_in,         // sda pad readback
  output logic                busy,
  output i2c_pkg::i2c_rsp_t   rsp,
  output logic                scl_ena,        // lets the timer's SCL reach the bus
  output logic                sda_drive_low
);

  i2c_pkg::engine_state_e state;
  i2c_pkg::addr_byte_u    addr_q;       // latched address and rw
  logic [7:0]             data_tx;      // latched write byte
  logic [7:0]             data_rx;      // read shift register
  logic [7:0]             data_rd;
  logic                   ack_error;
  logic [2:0]             bit_cnt;      // bit being sent or received
  logic                   sda_int;      // SDA level wanted during data bits
  logic                   data_level;   // high from data_rise to data_fall
  logic                   accept_point;
  logic                   accept;       // a new command is taken this cycle
  logic                   same_target;  // next command keeps address and rw

  assign same_target  = (addr_q.raw == cmd.addr_byte.raw);
  assign accept_point = (state == i2c_pkg::ready) ||
                        (state == i2c_pkg::slv_ack2) ||
                        (state == i2c_pkg::mstr_ack);
  assign accept       = phase.data_rise && ena && accept_point;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      data_level <= 1'b0;
    else if (phase.data_rise)
      data_level <= 1'b1;
    else if (phase.data_fall)
      data_level <= 1'b0;
  end

  // command latch and receive shifter
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q.fields <= cmd.addr_byte.fields;
      data_tx       <= cmd.data_wr;
    end
    if (phase.data_fall && state == i2c_pkg::rd)
      data_rx[bit_cnt] <= sda_in;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= i2c_pkg::ready;
      busy      <= 1'b1;
      scl_ena   <= 1'b0;
      sda_int   <= 1'b1;
      ack_error <= 1'b0;
      bit_cnt   <= 3'd7;
      data_rd   <= 8'h00;
    end else if (phase.data_rise) begin
      case (state)
        i2c_pkg::ready: begin
          if (accept) begin
            busy  <= 1'b1;
            state <= i2c_pkg::start;
          end else begin
            busy <= 1'b0;
          end
        end
        i2c_pkg::start: begin
          busy    <= 1'b1;
          sda_int <= addr_q.raw[bit_cnt];
          state   <= i2c_pkg::command;
        end
        i2c_pkg::command: begin
          if (bit_cnt == 3'd0) begin
            sda_int <= 1'b1;  // release for the target ack
            bit_cnt <= 3'd7;
            state   <= i2c_pkg::slv_ack1;
          end else begin
            bit_cnt <= bit_cnt - 3'd1;
            sda_int <= addr_q.raw[bit_cnt - 3'd1];
          end
        end
        i2c_pkg::slv_ack1: begin
          if (!addr_q.fields.rw) begin
            sda_int <= data_tx[bit_cnt];
            state   <= i2c_pkg::wr;
          end else begin
            sda_int <= 1'b1;
            state   <= i2c_pkg::rd;
          end
        end
        i2c_pkg::wr: begin
          busy <= 1'b1;
          if (bit_cnt == 3'd0) begin
            sda_int <= 1'b1;
            bit_cnt <= 3'd7;
            state   <= i2c_pkg::slv_ack2;
          end else begin
            bit_cnt <= bit_cnt - 3'd1;
            sda_int <= data_tx[bit_cnt - 3'd1];
          end
        end
        i2c_pkg::rd: begin
          busy <= 1'b1;
          if (bit_cnt == 3'd0) begin
            sda_int <= !(ena && same_target);  // ack only if another read follows
            bit_cnt <= 3'd7;
            data_rd <= data_rx;
            state   <= i2c_pkg::mstr_ack;
          end else begin
            bit_cnt <= bit_cnt - 3'd1;
          end
        end
        i2c_pkg::slv_ack2: begin
          if (accept) begin
            busy <= 1'b0;
            if (same_target) begin
              sda_int <= cmd.data_wr[bit_cnt];
              state   <= i2c_pkg::wr;
            end else begin
              state <= i2c_pkg::start;  // repeated start
            end
          end else begin
            state <= i2c_pkg::stop;
          end
        end
        i2c_pkg::mstr_ack: begin
          if (accept) begin
            busy <= 1'b0;
            if (same_target) begin
              sda_int <= 1'b1;
              state   <= i2c_pkg::rd;
            end else begin
              state <= i2c_pkg::start;
            end
          end else begin
            state <= i2c_pkg::stop;
          end
        end
        i2c_pkg::stop: begin
          busy  <= 1'b0;
          state <= i2c_pkg::ready;
        end
        default: state <= i2c_pkg::ready;
      endcase
    end else if (phase.data_fall) begin
      case (state)
        i2c_pkg::start:    scl_ena   <= 1'b1;
        i2c_pkg::slv_ack1: ack_error <= ack_error | sda_in;  // nack from target
        i2c_pkg::slv_ack2: ack_error <= ack_error | sda_in;
        i2c_pkg::stop:     scl_ena   <= 1'b0;
        default:           scl_ena   <= scl_ena;
      endcase
    end
  end

  // start pulls SDA low once SCL is high, stop releases it while SCL is high
  always_comb begin
    case (state)
      i2c_pkg::start: sda_drive_low = !data_level;
      i2c_pkg::stop:  sda_drive_low = data_level;
      default:        sda_drive_low = !sda_int;
    endcase
  end

  assign rsp = '{data_rd: data_rd, ack_error: ack_error};

endmodule

`default_nettype wire

//--- design/i2c_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              ena,
  input  i2c_pkg::i2c_cmd_t cmd,
  output logic              busy,
  output i2c_pkg::i2c_rsp_t rsp,
  inout  wire               sda,
  inout  wire               scl
);

  i2c_pkg::i2c_phase_t phase;
  logic                scl_ena;
  logic                sda_drive_low;
  logic                sda_in;
  logic                scl_in;

  i2c_bus_timer timer_i (
    .clk     (clk),
    .reset_n (reset_n),
    .scl_in  (scl_in),
    .phase   (phase)
  );

  i2c_byte_engine engine_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .ena           (ena),
    .cmd           (cmd),
    .phase         (phase),
    .sda_in        (sda_in),
    .busy          (busy),
    .rsp           (rsp),
    .scl_ena       (scl_ena),
    .sda_drive_low (sda_drive_low)
  );

  // open drain pads only ever pull the lines low
  assign sda = sda_drive_low ? 1'b0 : 1'bz;
  assign scl = (scl_ena && !phase.scl_level) ? 1'b0 : 1'bz;

  assign sda_in = sda;
  assign scl_in = scl;  // seen low by the timer when a target stretches

endmodule

`default_nettype wire

//--- design/i2c_params.svh
`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// system clock feeding the master in Hz
`define I2C_INPUT_CLK 32'd50000000

// target SCL rate in Hz
`define I2C_BUS_CLK 32'd400000

// system clocks per quarter of an SCL period
// the four quarters are low/low/high/high on SCL
// and the data edges sit at the first and third quarter
`define I2C_QUARTER ((`I2C_INPUT_CLK / `I2C_BUS_CLK) / 32'd4)

`endif

//--- design/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

  // address byte as it goes out on the wire
  typedef struct packed {
    logic [6:0] addr;  // seven-bit target address
    logic       rw;    // 1 for read
  } addr_fields_t;

  typedef union packed {
    logic [7:0]   raw;     // shifted out MSB first
    addr_fields_t fields;
  } addr_byte_u;

  typedef struct packed {
    addr_byte_u addr_byte;
    logic [7:0] data_wr;  // byte sent on a write
  } i2c_cmd_t;

  typedef struct packed {
    logic [7:0] data_rd;    // last byte read from the target
    logic       ack_error;  // sticky until reset
  } i2c_rsp_t;

  // one-cycle events and levels from the bus timer
  typedef struct packed {
    logic data_rise;   // SDA may change while SCL is low
    logic data_fall;   // SDA sampled while SCL is high
    logic scl_level;   // free-running SCL
    logic stretching;  // target is holding SCL low
  } i2c_phase_t;

  typedef enum logic [3:0] {
    ready, start, command, slv_ack1, wr, rd, slv_ack2, mstr_ack, stop
  } engine_state_e;

endpackage

`default_nettype wire

//--- flist.f
+incdir+design
design/i2c_pkg.sv
design/i2c_bus_timer.sv
design/i2c_byte_engine.sv
design/i2c_master_top.sv
tb/i2c_target_model.sv
tb/tb_i2c.sv

//--- tb/i2c_stim.txt
# id addr rw data hold exp_rd exp_ack, all hex
# hold=1 keeps ena high into the next line, exp_rd is checked on reads only
01 50 0 a5 0 00 0
02 50 1 00 0 a5 0
03 50 0 11 1 00 0
04 50 0 22 1 00 0
05 50 0 33 0 00 0
06 50 1 00 1 11 0
07 50 1 00 1 22 0
08 50 1 00 0 33 0
09 50 0 3c 1 00 0
0a 50 1 00 0 3c 0
0b 21 0 77 0 00 1

//--- tb/i2c_target_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_params.svh"

module i2c_target_model (
  input wire clk,
  inout wire sda,
  inout wire scl
);

  localparam logic [6:0] own_addr = 7'h50;

  logic [7:0] ring [0:7];
  logic [2:0] wr_ptr = 3'd0;
  logic [2:0] rd_ptr = 3'd0;
  logic [7:0] shift = 8'h00;
  int         bit_cnt = 0;
  int         hold;
  integer     seed = 32'hcabbabe2;
  logic       idle = 1'b1;       // no transfer since the last stop
  logic       addr_phase = 1'b0;
  logic       active = 1'b0;     // our address was seen
  logic       reading = 1'b0;
  logic       in_ack = 1'b0;     // ninth clock of a byte
  logic       addr_ack = 1'b0;
  logic       sending = 1'b0;
  logic       send_next = 1'b0;
  logic       sda_low = 1'b0;
  logic       scl_low = 1'b0;

  assign sda = sda_low ? 1'b0 : 1'bz;
  assign scl = scl_low ? 1'b0 : 1'bz;

  always @(negedge sda) begin
    if (scl === 1'b1) begin  // start or repeated start
      idle       = 1'b0;
      addr_phase = 1'b1;
      active     = 1'b0;
      in_ack     = 1'b0;
      sending    = 1'b0;
      bit_cnt    = 0;
    end
  end

  always @(posedge sda) begin
    if (scl === 1'b1) begin  // stop
      idle    = 1'b1;
      active  = 1'b0;
      sending = 1'b0;
      sda_low = 1'b0;
    end
  end

  always @(posedge scl) begin
    if (!idle) begin
      if (in_ack) begin
        if (active && reading && !addr_ack)
          send_next = (sda === 1'b0);  // master ack asks for one more byte
      end else begin
        shift   = {shift[6:0], sda === 1'b1};
        bit_cnt = bit_cnt + 1;
      end
    end
  end

  always @(negedge scl) begin
    if (!idle) begin
      if (in_ack) begin
        in_ack   = 1'b0;
        addr_ack = 1'b0;
        bit_cnt  = 0;
        sda_low  = 1'b0;
        sending  = active && reading && send_next;
        if (sending)
          sda_low = !ring[rd_ptr][7];
        if (active) begin
          // hold SCL past the master's own low phase
          scl_low = 1'b1;
          hold    = 2 * `I2C_QUARTER + $unsigned($random(seed)) % 41;
          repeat (hold) @(posedge clk);
          @(negedge clk);
          scl_low = 1'b0;
        end
      end else if (bit_cnt == 8) begin
        in_ack = 1'b1;
        if (addr_phase) begin
          addr_phase = 1'b0;
          addr_ack   = 1'b1;
          active     = (shift[7:1] == own_addr);
          reading    = shift[0];
          send_next  = shift[0];
          sda_low    = active;
        end else if (active && !reading) begin
          ring[wr_ptr] = shift;
          wr_ptr       = wr_ptr + 3'd1;
          sda_low      = 1'b1;
        end else begin
          sda_low = 1'b0;  // master drives its ack bit
          sending = 1'b0;
          if (active)
            rd_ptr = rd_ptr + 3'd1;
        end
      end else if (sending) begin
        sda_low = !ring[rd_ptr][7 - bit_cnt];
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_i2c.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_params.svh"

module tb_i2c;

  localparam int max_lines = 64;

  logic              clk = 1'b0;
  logic              reset_n;
  logic              ena;
  i2c_pkg::i2c_cmd_t cmd;
  logic              busy;
  i2c_pkg::i2c_rsp_t rsp;
  tri1               sda;  // pull-ups
  tri1               scl;

  logic [7:0] t_id [max_lines];
  logic [7:0] t_addr [max_lines];
  logic       t_rw [max_lines];
  logic [7:0] t_data [max_lines];
  logic       t_hold [max_lines];
  logic [7:0] t_exp_rd [max_lines];
  logic       t_exp_ack [max_lines];
  int         n_lines = 0;
  int         failed = 0;
  int         limit_cycles = 0;
  logic       loaded = 1'b0;

  i2c_master_top dut_i (
    .clk     (clk),
    .reset_n (reset_n),
    .ena     (ena),
    .cmd     (cmd),
    .busy    (busy),
    .rsp     (rsp),
    .sda     (sda),
    .scl     (scl)
  );

  i2c_target_model target_i (
    .clk (clk),
    .sda (sda),
    .scl (scl)
  );

  always #5 clk = ~clk;

  task automatic load_stim();
    int    fd;
    string line;
    int    id, addr, rw, data, hold, exp_rd, exp_ack;
    fd = $fopen("tb/i2c_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tb/i2c_stim.txt");
      failed++;
      return;
    end
    while (!$feof(fd) && n_lines < max_lines) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#" &&
          $sscanf(line, "%h %h %h %h %h %h %h", id, addr, rw, data, hold, exp_rd,
                  exp_ack) == 7) begin
        t_id[n_lines]      = id[7:0];
        t_addr[n_lines]    = addr[7:0];
        t_rw[n_lines]      = rw[0];
        t_data[n_lines]    = data[7:0];
        t_hold[n_lines]    = hold[0];
        t_exp_rd[n_lines]  = exp_rd[7:0];
        t_exp_ack[n_lines] = exp_ack[0];
        n_lines++;
      end
    end
    $fclose(fd);
  endtask

  function automatic i2c_pkg::i2c_cmd_t make_cmd(input int i);
    i2c_pkg::i2c_cmd_t c;
    c.addr_byte.fields.addr = t_addr[i][6:0];
    c.addr_byte.fields.rw   = t_rw[i];
    c.data_wr               = t_data[i];
    return c;
  endfunction

  // one address byte opens each transaction and each repeated start
  function automatic int count_bus_bytes();
    int n;
    n = n_lines;
    for (int i = 0; i < n_lines; i++) begin
      if (i == 0 || !t_hold[i - 1])
        n++;
      else if (t_addr[i] != t_addr[i - 1] || t_rw[i] != t_rw[i - 1])
        n++;
    end
    return n;
  endfunction

  // sampled on the falling edge away from DUT updates
  task automatic wait_busy(input logic level);
    do
      @(negedge clk);
    while (busy !== level);
  endtask

  task automatic run_line(input int i);
    int errs;
    errs = 0;
    if (!ena) begin  // fresh transaction from ready
      @(posedge clk);
      cmd <= make_cmd(i);
      ena <= 1'b1;
    end
    wait_busy(1'b1);
    @(posedge clk);
    if (t_hold[i] && i + 1 < n_lines)
      cmd <= make_cmd(i + 1);
    else
      ena <= 1'b0;
    wait_busy(1'b0);  // byte done and the next one accepted or the bus stopped
    if (t_rw[i] && rsp.data_rd !== t_exp_rd[i]) begin
      $display("[ERROR] test %02h rsp.data_rd got 0x%02h expected 0x%02h", t_id[i],
               rsp.data_rd, t_exp_rd[i]);
      errs++;
    end
    if (rsp.ack_error !== t_exp_ack[i]) begin
      $display("[ERROR] test %02h rsp.ack_error got 0x%01h expected 0x%01h", t_id[i],
               rsp.ack_error, t_exp_ack[i]);
      errs++;
    end
    if (errs != 0)
      failed++;
    $display("test %02h addr %02h rw %0d: %s", t_id[i], t_addr[i], t_rw[i],
             (errs == 0) ? "ok" : "FAILED");
  endtask

  task automatic check_after_reset();
    int errs;
    errs = 0;
    @(posedge clk);
    reset_n <= 1'b0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    if (rsp.ack_error !== 1'b0) begin
      $display("[ERROR] reset rsp.ack_error got 0x%01h expected 0x0", rsp.ack_error);
      errs++;
    end
    if (sda !== 1'b1) begin
      $display("[ERROR] reset sda got 0x%01h expected 0x1", sda);
      errs++;
    end
    if (scl !== 1'b1) begin
      $display("[ERROR] reset scl got 0x%01h expected 0x1", scl);
      errs++;
    end
    if (errs != 0)
      failed++;
    $display("reset check: %s", (errs == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    wait (loaded);
    repeat (limit_cycles) @(posedge clk);
    $display("run timed out after %0d cycles, engine in state %s", limit_cycles,
             dut_i.engine_i.state.name());
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset_n = 1'b0;
    ena     = 1'b0;
    cmd     = '0;
    load_stim();
    // ten SCL periods for each bus byte plus one for the reset check with a margin of two
    limit_cycles = (count_bus_bytes() + 1) * 10 * 4 * `I2C_QUARTER * 2;
    loaded       = 1'b1;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    wait_busy(1'b0);
    for (int i = 0; i < n_lines; i++)
      run_line(i);
    check_after_reset();
    $display("tests run: %0d, failed: %0d", n_lines + 1, failed);
    if (failed == 0 && n_lines > 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
